//--- trs_io.f
rtl/trs_io_pkg.sv
rtl/cmd_if.sv
rtl/esp_spi_slave.sv
rtl/cmd_framer.sv
rtl/cmd_fifo.sv
rtl/cmd_exec.sv
rtl/flash_spi_master.sv
rtl/trs_io_top.sv
sim/tb_clk_gen.sv
sim/tb_trs_io.sv

//--- Makefile
# Verilator simulation of the ESP link testbench

VERILATOR ?= verilator
TOP       ?= tb_trs_io
FILELIST  ?= trs_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_trs_io.sv
`timescale 1ns/1ps

module tb_trs_io;

  localparam int RESET_CYCLES = 8;
  localparam int SCK_HALF     = 6;
  // cs setup, eight sck periods, trailing low half and cs hold
  localparam int BYTE_CYCLES  = 10 + 17 * SCK_HALF;
  localparam int XFER_CYCLES  = 140;
  localparam int SPI_BYTES    = 27;
  localparam int XFER_COUNT   = 4;
  localparam int FLASH_WAIT_CYCLES = 2 * XFER_CYCLES;
  // all test bytes and flash transfers plus half again
  localparam int WATCHDOG_CYCLES =
    (SPI_BYTES * BYTE_CYCLES + XFER_COUNT * XFER_CYCLES + 2 * RESET_CYCLES) * 3 / 2;
  localparam int RANDOM_SEED  = 44;

  localparam logic [7:0] OP_GET_COOKIE       = 8'd0;
  localparam logic [7:0] OP_GET_VERSION      = 8'd15;
  localparam logic [7:0] OP_SET_SCREEN_COLOR = 8'd17;
  localparam logic [7:0] OP_SET_LED          = 8'd26;
  localparam logic [7:0] OP_SET_SPI_CTRL_REG = 8'd29;
  localparam logic [7:0] OP_SET_SPI_DATA     = 8'd30;
  localparam logic [7:0] OP_GET_SPI_DATA     = 8'd31;
  localparam logic [7:0] OP_SET_ESP_STATUS   = 8'd32;
  localparam logic [7:0] OP_UNKNOWN          = 8'hFE;
  // the dummy byte is a harmless get_cookie
  localparam logic [7:0] DUMMY               = OP_GET_COOKIE;

  localparam logic [7:0]  COOKIE_EXP  = 8'hAF;
  // major 0 in bits 7..5 and minor 3 in bits 4..0
  localparam logic [7:0]  VERSION_EXP = {3'd0, 5'd3};
  localparam logic [23:0] WHITE       = 24'hFFFFFF;

  logic        clk;
  logic        cass_out_sel_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  wire         miso;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  logic [7:0]  esp_status;
  logic [23:0] screen_color;
  logic        spi_error;
  logic        flash_cs_n;
  logic        flash_clk;
  logic        flash_si;
  logic        flash_so = 1'b0;

  int errors;
  int tests_run;
  int tests_failed;

  // flash model state
  logic [7:0] so_q [$];
  bit   [2:0] so_bits;
  logic [7:0] si_sr;
  bit   [2:0] si_bits;
  logic [7:0] si_seen [$];
  int         flash_pulses;
  bit         fclk_prev;

  tb_clk_gen u_clk (
    .clk (clk)
  );

  trs_io_top u_dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .spi_error      (spi_error),
    .flash_cs_n     (flash_cs_n),
    .flash_clk      (flash_clk),
    .flash_si       (flash_si),
    .flash_so       (flash_so)
  );

  // flash model samples flash_clk on falling clk where it is settled
  always @(negedge clk) begin
    if (flash_clk && !fclk_prev) begin
      flash_pulses = flash_pulses + 1;
      si_sr = {si_sr[6:0], flash_si};
      si_bits = si_bits + 3'd1;
      if (si_bits == 3'd0) begin
        si_seen.push_back(si_sr);
      end
    end
    if (!flash_clk && fclk_prev) begin
      // next stored byte once the last bit is gone
      if (so_bits == 3'd7 && so_q.size() > 0) begin
        so_q.delete(0);
      end
      so_bits = so_bits + 3'd1;
    end
    fclk_prev = flash_clk;
    if (so_q.size() > 0) begin
      flash_so = so_q[0][~so_bits];
    end else begin
      flash_so = 1'b0;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failed checks", name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    cass_out_sel_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  // esp side in spi mode 0 with one byte per cs frame
  // a byte ends 16 clk after its last sck rise, later than the
  // strobe, framer, fifo and executor steps added together
  task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = 8'h00;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      mosi = tx[7 - i];
      repeat (SCK_HALF) @(negedge clk);
      // miso moved after the previous falling sck
      if (i > 0) begin
        rx = {rx[6:0], miso};
      end
      sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge clk);
    rx = {rx[6:0], miso};
    cs_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic send_byte(input logic [7:0] tx);
    logic [7:0] unused_rx;
    exchange_byte(tx, unused_rx);
  endtask

  task automatic wait_flash_bytes(input int count);
    int n;
    n = 0;
    while (si_seen.size() < count && n < FLASH_WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (si_seen.size() < count) begin
      $display("flash transfer did not finish at t=%0t, model saw %0d of %0d bytes",
               $time, si_seen.size(), count);
      errors++;
    end
  endtask

  task automatic readback_constants();
    logic [7:0] rx;
    int         err_before;
    err_before = errors;
    send_byte(OP_GET_COOKIE);
    exchange_byte(DUMMY, rx);
    if (rx !== COOKIE_EXP) report_mismatch("miso", 32'(COOKIE_EXP), 32'(rx));
    send_byte(OP_GET_VERSION);
    exchange_byte(DUMMY, rx);
    if (rx !== VERSION_EXP) report_mismatch("miso", 32'(VERSION_EXP), 32'(rx));
    close_test("readback", err_before);
  endtask

  task automatic register_writes();
    logic [7:0] led_val;
    logic [7:0] status_val;
    logic [7:0] color [3];
    int         err_before;
    err_before = errors;
    led_val = 8'($urandom());
    send_byte(OP_SET_LED);
    send_byte(led_val);
    if (led_red !== led_val[0]) report_mismatch("led_red", 32'(led_val[0]), 32'(led_red));
    if (led_green !== led_val[1]) begin
      report_mismatch("led_green", 32'(led_val[1]), 32'(led_green));
    end
    if (led_blue !== led_val[2]) report_mismatch("led_blue", 32'(led_val[2]), 32'(led_blue));
    status_val = 8'($urandom());
    send_byte(OP_SET_ESP_STATUS);
    send_byte(status_val);
    if (esp_status !== status_val) begin
      report_mismatch("esp_status", 32'(status_val), 32'(esp_status));
    end
    for (int i = 0; i < 3; i++) begin
      color[i] = 8'($urandom());
    end
    send_byte(OP_SET_SCREEN_COLOR);
    for (int i = 0; i < 3; i++) begin
      send_byte(color[i]);
    end
    // first byte sent ends up in the top bits
    if (screen_color !== {color[0], color[1], color[2]}) begin
      report_mismatch("screen_color", 32'({color[0], color[1], color[2]}), 32'(screen_color));
    end
    close_test("register writes", err_before);
  endtask

  task automatic flash_exchange();
    logic [7:0] tx_val;
    logic [7:0] flash_val;
    logic [7:0] rx;
    int         seen_before;
    int         pulses_before;
    int         err_before;
    err_before = errors;
    send_byte(OP_SET_SPI_CTRL_REG);
    send_byte(8'h80);
    if (flash_cs_n !== 1'b0) report_mismatch("flash_cs_n", 32'd0, 32'(flash_cs_n));
    tx_val = 8'($urandom());
    flash_val = 8'($urandom());
    so_q.push_back(flash_val);
    seen_before = si_seen.size();
    pulses_before = flash_pulses;
    send_byte(OP_SET_SPI_DATA);
    send_byte(tx_val);
    wait_flash_bytes(seen_before + 1);
    if (si_seen.size() > seen_before && si_seen[seen_before] !== tx_val) begin
      report_mismatch("flash_si", 32'(tx_val), 32'(si_seen[seen_before]));
    end
    send_byte(OP_GET_SPI_DATA);
    exchange_byte(DUMMY, rx);
    if (rx !== flash_val) report_mismatch("miso", 32'(flash_val), 32'(rx));
    // the whole transfer is over by now
    if (flash_pulses - pulses_before != 8) begin
      report_mismatch("flash_clk pulses", 32'd8, 32'(flash_pulses - pulses_before));
    end
    close_test("flash exchange", err_before);
  endtask

  task automatic flash_backpressure();
    logic [7:0] tx_val [3];
    logic [7:0] flash_val [3];
    logic [7:0] rx;
    int         seen_before;
    int         err_before;
    err_before = errors;
    seen_before = si_seen.size();
    for (int i = 0; i < 3; i++) begin
      flash_val[i] = 8'($urandom());
      tx_val[i] = 8'($urandom());
      so_q.push_back(flash_val[i]);
    end
    for (int i = 0; i < 3; i++) begin
      send_byte(OP_SET_SPI_DATA);
      send_byte(tx_val[i]);
    end
    wait_flash_bytes(seen_before + 3);
    for (int i = 0; i < 3; i++) begin
      if (si_seen.size() > seen_before + i && si_seen[seen_before + i] !== tx_val[i]) begin
        report_mismatch("flash_si", 32'(tx_val[i]), 32'(si_seen[seen_before + i]));
      end
    end
    send_byte(OP_GET_SPI_DATA);
    exchange_byte(DUMMY, rx);
    if (rx !== flash_val[2]) report_mismatch("miso", 32'(flash_val[2]), 32'(rx));
    if (spi_error !== 1'b0) report_mismatch("spi_error", 32'd0, 32'(spi_error));
    close_test("flash back-pressure", err_before);
  endtask

  task automatic error_flag();
    logic [2:0]  led_before;
    logic [7:0]  status_before;
    logic [23:0] color_before;
    int          err_before;
    err_before = errors;
    led_before = {led_blue, led_green, led_red};
    status_before = esp_status;
    color_before = screen_color;
    send_byte(OP_UNKNOWN);
    if (spi_error !== 1'b1) report_mismatch("spi_error", 32'd1, 32'(spi_error));
    if ({led_blue, led_green, led_red} !== led_before) begin
      report_mismatch("led", 32'(led_before), 32'({led_blue, led_green, led_red}));
    end
    if (esp_status !== status_before) begin
      report_mismatch("esp_status", 32'(status_before), 32'(esp_status));
    end
    if (screen_color !== color_before) begin
      report_mismatch("screen_color", 32'(color_before), 32'(screen_color));
    end
    apply_reset();
    if (spi_error !== 1'b0) report_mismatch("spi_error", 32'd0, 32'(spi_error));
    // everything back at reset values
    if ({led_blue, led_green, led_red} !== 3'b000) begin
      report_mismatch("led", 32'd0, 32'({led_blue, led_green, led_red}));
    end
    if (esp_status !== 8'h00) report_mismatch("esp_status", 32'd0, 32'(esp_status));
    if (screen_color !== WHITE) report_mismatch("screen_color", 32'(WHITE), 32'(screen_color));
    if (flash_cs_n !== 1'b1) report_mismatch("flash_cs_n", 32'd1, 32'(flash_cs_n));
    close_test("error flag", err_before);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired at t=%0t, the tests did not finish in time", $time);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    cass_out_sel_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    void'($urandom(RANDOM_SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (4) @(negedge clk);
    readback_constants();
    register_writes();
    flash_exchange();
    flash_backpressure();
    error_flag();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

//--- rtl/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  output logic  led_red,
  output logic  led_green,
  output logic  led_blue,
  output byte_t esp_status,
  output rgb_t  screen_color,
  output logic  spi_error,
  output logic  flash_cs_n,
  output logic  flash_clk,
  output logic  flash_si,
  input  logic  flash_so
);

  logic  byte_strobe;
  byte_t rx_byte;
  byte_t resp_byte;

  cmd_if   frm_cmd ();
  cmd_if   fifo_cmd ();
  flash_if flash_bus ();

  esp_spi_slave u_slave (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .resp_byte      (resp_byte),
    .byte_strobe    (byte_strobe),
    .rx_byte        (rx_byte)
  );

  cmd_framer u_framer (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_strobe    (byte_strobe),
    .rx_byte        (rx_byte),
    .cmd            (frm_cmd.source),
    .spi_error      (spi_error)
  );

  cmd_fifo u_fifo (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .in             (frm_cmd.sink),
    .out            (fifo_cmd.source)
  );

  // led bit 0 red, 1 green, 2 blue
  cmd_exec u_exec (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (fifo_cmd.sink),
    .flash          (flash_bus.requester),
    .resp_byte      (resp_byte),
    .led            ({led_blue, led_green, led_red}),
    .esp_status     (esp_status),
    .screen_color   (screen_color)
  );

  flash_spi_master u_flash (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .flash          (flash_bus.engine),
    .flash_cs_n     (flash_cs_n),
    .flash_clk      (flash_clk),
    .flash_si       (flash_si),
    .flash_so       (flash_so)
  );

endmodule

//--- rtl/flash_spi_master.sv
`timescale 1ns/1ps

module flash_spi_master
  import trs_io_pkg::*;
(
  input  logic    clk,
  input  logic    cass_out_sel_n,
  flash_if.engine flash,
  output logic    flash_cs_n,
  output logic    flash_clk,
  output logic    flash_si,
  input  logic    flash_so
);

  // cnt[7] marks a transfer, cnt[3] is the flash clock
  flash_cnt_t cnt;
  byte_t      shift_sr;
  // bit 7 of the control register, chip select active high
  logic       cs_en;
  logic       sdo;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cnt   <= '0;
      cs_en <= 1'b0;
      sdo   <= 1'b0;
    end else begin
      if (flash.ctrl_we) begin
        cs_en <= flash.ctrl_data[7];
      end
      if (cnt[7]) begin
        cnt <= cnt + 8'd1;
        // new bit at the start of each low half
        if (cnt[3:0] == 4'b0000) begin
          sdo <= shift_sr[7];
        end
      end else if (flash.start) begin
        cnt <= 8'h80;
      end
    end
  end

  // received bits replace the sent ones
  always_ff @(posedge clk) begin
    if (cnt[7]) begin
      if (cnt[3:0] == 4'b0111) begin
        shift_sr <= {shift_sr[6:0], flash_so};
      end
    end else if (flash.start) begin
      shift_sr <= flash.tx_data;
    end
  end

  assign flash.busy    = cnt[7];
  assign flash.rx_data = shift_sr;
  assign flash_cs_n    = ~cs_en;
  assign flash_clk     = cnt[3];
  assign flash_si      = sdo;

  a_start_idle: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    flash.start |-> !flash.busy);

endmodule

//--- rtl/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec
  import trs_io_pkg::*;
(
  input  logic       clk,
  input  logic       cass_out_sel_n,
  cmd_if.sink        cmd,
  flash_if.requester flash,
  output byte_t      resp_byte,
  output led_t       led,
  output byte_t      esp_status,
  output rgb_t       screen_color
);

  exec_state_t state;
  logic        take;

  assign cmd.ready = (state == exec_idle);
  assign take      = cmd.valid && cmd.ready;

  // flash requests leave in the handshake cycle
  // busy is always low in exec_idle
  assign flash.ctrl_we   = take && (cmd.opcode == op_set_spi_ctrl_reg);
  assign flash.ctrl_data = cmd.params[0];
  assign flash.start     = take && (cmd.opcode == op_set_spi_data);
  assign flash.tx_data   = cmd.params[0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state        <= exec_idle;
      resp_byte    <= '0;
      led          <= '0;
      esp_status   <= '0;
      screen_color <= SCREEN_COLOR_RESET;
    end else begin
      case (state)
        exec_idle: begin
          if (take) begin
            case (cmd.opcode)
              op_get_cookie:       resp_byte <= COOKIE;
              op_get_version:      resp_byte <= {VERSION_MAJOR, VERSION_MINOR};
              op_get_spi_data:     resp_byte <= flash.rx_data;
              op_set_led:          led <= cmd.params[0][2:0];
              op_set_esp_status:   esp_status <= cmd.params[0];
              op_set_screen_color: begin
                screen_color <= {cmd.params[0], cmd.params[1], cmd.params[2]};
              end
              // hold off further commands until the byte is out
              op_set_spi_data:     state <= exec_flash_wait;
              default: ;
            endcase
          end
        end
        exec_flash_wait: begin
          if (!flash.busy) begin
            state <= exec_idle;
          end
        end
        default: state <= exec_idle;
      endcase
    end
  end

endmodule

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  cmd_if.sink   in,
  cmd_if.source out
);

  opcode_t                op_mem  [FIFO_DEPTH];
  byte_t [MAX_PARAMS-1:0] par_mem [FIFO_DEPTH];
  fifo_ptr_t              wr_ptr;
  fifo_ptr_t              rd_ptr;
  logic                   full;
  logic                   empty;
  logic                   push;
  logic                   pop;

  assign empty = (wr_ptr == rd_ptr);
  // same slot on the other lap
  assign full  = (wr_ptr == (rd_ptr ^ fifo_ptr_t'(FIFO_DEPTH)));

  assign in.ready   = !full;
  assign out.valid  = !empty;
  assign push       = in.valid && in.ready;
  assign pop        = out.valid && out.ready;
  assign out.opcode = op_mem[rd_ptr[1:0]];
  assign out.params = par_mem[rd_ptr[1:0]];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 3'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr[1:0]]  <= in.opcode;
      par_mem[wr_ptr[1:0]] <= in.params;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    full && !pop |=> wr_ptr == $past(wr_ptr));

endmodule

//--- rtl/cmd_framer.sv
`timescale 1ns/1ps

module cmd_framer
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  byte_strobe,
  input  byte_t rx_byte,
  cmd_if.source cmd,
  output logic  spi_error
);

  logic                   collecting;
  param_count_t           remaining;
  param_idx_t             idx;
  opcode_t                asm_op;
  byte_t [MAX_PARAMS-1:0] asm_params;
  logic                   op_known;
  param_count_t           op_count;
  opcode_t                op_next;
  byte_t [MAX_PARAMS-1:0] params_next;
  logic                   last_byte;
  logic                   load_out;

  // parameter count per opcode
  always_comb begin
    op_known = 1'b1;
    op_count = '0;
    case (rx_byte)
      op_get_cookie, op_get_version, op_get_spi_data: op_count = 2'd0;
      op_set_screen_color: op_count = 2'd3;
      op_set_led, op_set_spi_ctrl_reg, op_set_spi_data, op_set_esp_status: op_count = 2'd1;
      default: op_known = 1'b0;
    endcase
  end

  // command as it stands with the current byte folded in
  always_comb begin
    op_next     = collecting ? asm_op : rx_byte;
    params_next = asm_params;
    if (collecting) begin
      params_next[idx] = rx_byte;
    end
  end

  assign last_byte = byte_strobe &&
                     (collecting ? (remaining == 2'd1) : (op_known && op_count == 2'd0));
  // a held command blocks the new one
  assign load_out  = last_byte && !(cmd.valid && !cmd.ready);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      collecting <= 1'b0;
      remaining  <= '0;
      idx        <= '0;
      cmd.valid  <= 1'b0;
      spi_error  <= 1'b0;
    end else begin
      if (cmd.valid && cmd.ready) begin
        cmd.valid <= 1'b0;
      end
      if (byte_strobe) begin
        if (collecting) begin
          idx       <= idx + 2'd1;
          remaining <= remaining - 2'd1;
          if (remaining == 2'd1) begin
            collecting <= 1'b0;
          end
        end else if (!op_known) begin
          spi_error <= 1'b1;
        end else if (op_count != 2'd0) begin
          collecting <= 1'b1;
          remaining  <= op_count;
          idx        <= '0;
        end
      end
      if (load_out) begin
        cmd.valid <= 1'b1;
      end else if (last_byte) begin
        // overrun, command lost
        spi_error <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_strobe) begin
      asm_op     <= op_next;
      asm_params <= params_next;
    end
    if (load_out) begin
      cmd.opcode <= op_next;
      cmd.params <= params_next;
    end
  end

  a_payload_stable: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.opcode) && $stable(cmd.params));

endmodule

//--- rtl/esp_spi_slave.sv
`timescale 1ns/1ps

module esp_spi_slave
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  input  byte_t resp_byte,
  output logic  byte_strobe,
  output byte_t rx_byte
);

  // two sync stages, third sck bit only for edge detect
  logic [2:0] sck_r;
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;
  byte_t      tx_sr;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;

  assign cs_active = ~cs_r[1];
  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r       <= '0;
      cs_r        <= 2'b11;
      bit_cnt     <= '0;
      byte_strobe <= 1'b0;
    end else begin
      sck_r       <= {sck_r[1:0], sck};
      cs_r        <= {cs_r[0], cs_n};
      byte_strobe <= 1'b0;
      // cs high drops any partial byte
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt     <= bit_cnt + 3'd1;
        byte_strobe <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    mosi_r <= {mosi_r[0], mosi};
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_r[1]};
    end
    // first falling edge of a byte picks up the response
    if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd1) begin
        tx_sr <= resp_byte;
      end else begin
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
    end
  end

  assign miso = cs_active ? tx_sr[7] : 1'bz;

  a_strobe_single: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    byte_strobe |=> !byte_strobe);

endmodule

//--- rtl/cmd_if.sv
`timescale 1ns/1ps

// one framed command with valid/ready
interface cmd_if
  import trs_io_pkg::*;
();
  logic                   valid;
  logic                   ready;
  opcode_t                opcode;
  byte_t [MAX_PARAMS-1:0] params;

  modport source (output valid, output opcode, output params, input ready);
  modport sink   (input valid, input opcode, input params, output ready);
endinterface

// executor requests to the config flash master
interface flash_if
  import trs_io_pkg::*;
();
  logic  ctrl_we;
  byte_t ctrl_data;
  logic  start;
  byte_t tx_data;
  logic  busy;
  byte_t rx_data;

  modport requester (
    output ctrl_we, output ctrl_data, output start, output tx_data,
    input  busy, input rx_data
  );
  modport engine (
    input  ctrl_we, input ctrl_data, input start, input tx_data,
    output busy, output rx_data
  );
endinterface

//--- rtl/trs_io_pkg.sv
package trs_io_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [1:0]  param_idx_t;
  typedef logic [1:0]  param_count_t;
  typedef logic [23:0] rgb_t;
  typedef logic [2:0]  led_t;
  typedef logic [2:0]  fifo_ptr_t;
  typedef logic [7:0]  flash_cnt_t;

  // opcodes from the esp
  localparam opcode_t op_get_cookie       = 8'd0;
  localparam opcode_t op_get_version      = 8'd15;
  localparam opcode_t op_set_screen_color = 8'd17;
  localparam opcode_t op_set_led          = 8'd26;
  localparam opcode_t op_set_spi_ctrl_reg = 8'd29;
  localparam opcode_t op_set_spi_data     = 8'd30;
  localparam opcode_t op_get_spi_data     = 8'd31;
  localparam opcode_t op_set_esp_status   = 8'd32;

  // set_screen_color carries the most parameters
  localparam int MAX_PARAMS = 3;
  localparam int FIFO_DEPTH = 4;

  localparam byte_t COOKIE = 8'hAF;

  // version byte is {major, minor}
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  localparam rgb_t SCREEN_COLOR_RESET = 24'hFFFFFF;

  typedef enum logic {
    exec_idle,
    exec_flash_wait
  } exec_state_t;

endpackage
